// File: source/bus_ctrl_consts.svh
`ifndef BUS_CTRL_CONSTS_SVH
`define BUS_CTRL_CONSTS_SVH

`define SW_WIDTH            18      // front-panel switch word
`define DATA_WIDTH          16      // master data word
`define ADDR_WIDTH          12      // log2 of the deepest slave
`define MASTER_COUNT        2

`define BANK_DEPTH          16      // externally entered words per master
`define BANK_ADDR_WIDTH     4

// slave depth table, slave ids 1 to 3
`define SLAVE_DEPTH_1       4096
`define SLAVE_DEPTH_2       4096
`define SLAVE_DEPTH_3       2048

`define CONFIG_CLK_COUNT    2       // cycles per config sub-state
`define COM_START_DELAY     3       // stagger between the two launch pulses
`define FIRST_START_MASTER  0

`define DEBOUNCE_CYCLES     8       // kept short for simulation

`endif

// File: source/bus_ctrl_pkg.sv
`include "bus_ctrl_consts.svh"

package bus_ctrl_pkg;

    typedef enum logic [3:0] {
        slave_select,
        rw_select,
        ext_write_select,
        ext_write_m0,
        ext_write_m01,
        ext_write_m1,
        start_addr_m0,
        start_addr_m1,
        length_m0,
        length_m1,
        configuring,
        comm_ready,
        communicating,
        comm_done
    } session_state_t;

    typedef enum logic [1:0] {
        cfg_start,
        cfg_middle,
        cfg_last,
        cfg_done
    } config_state_t;

    typedef logic [1:0] slave_id_t;  // 0 keeps the master idle

    // bits 1:0 double as the per-master flags in the rw and ext phases
    typedef struct packed {
        logic [`SW_WIDTH-2*`MASTER_COUNT-1:0] spare;
        slave_id_t [`MASTER_COUNT-1:0]         sid;
    } sw_sel_t;

    typedef struct packed {
        logic [`SW_WIDTH-`ADDR_WIDTH-1:0] spare;
        logic [`ADDR_WIDTH-1:0]           value;  // start address or length
    } sw_val_t;

    typedef union packed {
        sw_sel_t sel;
        sw_val_t val;
    } sw_word_t;

endpackage

// File: source/key_debouncer.sv
`timescale 1ns/1ns
`include "bus_ctrl_consts.svh"

module key_debouncer #(
    parameter int DELAY_CYCLES = `DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rstN,
    input  logic key_n,
    output logic press
);
    logic [1:0]                        sync;   // two-stage synchronizer
    logic                              held;   // debounced level, high while pressed
    logic [$clog2(DELAY_CYCLES)-1:0]   count;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sync  <= 2'b11;
            held  <= 1'b0;
            count <= '0;
            press <= 1'b0;
        end else begin
            sync  <= {sync[0], key_n};
            press <= 1'b0;
            // key is active low, so equal values mean the raw key disagrees with held
            if (sync[1] == held) begin
                count <= count + 1'b1;
                if (count == DELAY_CYCLES - 1) begin
                    held  <= ~held;
                    count <= '0;
                    press <= ~held;  // pulse on the press edge only
                end
            end else begin
                count <= '0;
            end
        end
    end

endmodule

// File: source/write_data_bank.sv
`timescale 1ns/1ns
`include "bus_ctrl_consts.svh"

module write_data_bank (
    input  logic                        clk,
    input  logic                        we,
    input  logic                        wr_master,
    input  logic [`BANK_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`DATA_WIDTH-1:0]      wr_data,
    input  logic                        rd_master,
    input  logic [`BANK_ADDR_WIDTH-1:0] rd_addr,
    output logic [`DATA_WIDTH-1:0]      rd_data
);
    logic [`DATA_WIDTH-1:0] mem [`MASTER_COUNT][`BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_master][wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_master][rd_addr];  // one cycle read latency
    end

endmodule

// File: source/session_fsm.sv
`timescale 1ns/1ns
`include "bus_ctrl_consts.svh"

module session_fsm import bus_ctrl_pkg::*; (
    input  logic                                       clk,
    input  logic                                       rstN,
    input  logic                                       step_press,
    input  logic                                       addr_press,
    input  sw_word_t                                   sw,
    input  logic                                       cfg_done,
    input  logic [`MASTER_COUNT-1:0]                   done_com,
    output session_state_t                             state,
    output slave_id_t [`MASTER_COUNT-1:0]              slave_id,
    output logic [`MASTER_COUNT-1:0]                   rd_wr,
    output logic [`MASTER_COUNT-1:0]                   in_ex,
    output logic [`MASTER_COUNT-1:0]                   burst,
    output logic [`MASTER_COUNT-1:0]                   eoc,
    output logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]  first_addr,
    output logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]  last_addr,
    output logic [`MASTER_COUNT-1:0][`BANK_ADDR_WIDTH:0] word_count,
    output logic                                       bank_we,
    output logic                                       bank_master,
    output logic [`BANK_ADDR_WIDTH-1:0]                bank_addr,
    output logic [`DATA_WIDTH-1:0]                     bank_data,
    output logic                                       cfg_go,
    output logic                                       launch
);
    logic [`MASTER_COUNT-1:0]       flags;
    logic                           ext_phase;
    logic [`BANK_ADDR_WIDTH-1:0]    wr_addr;
    logic                           val_master;  // master of the current address or length phase
    logic [`ADDR_WIDTH:0]           span_end;
    logic [`ADDR_WIDTH:0]           span_depth;
    logic [`ADDR_WIDTH:0]           span_last;
    logic                           all_done;

    function automatic logic [`ADDR_WIDTH:0] depth_of(slave_id_t id);
        case (id)
            2'd2:    return (`ADDR_WIDTH+1)'(`SLAVE_DEPTH_2);
            2'd3:    return (`ADDR_WIDTH+1)'(`SLAVE_DEPTH_3);
            default: return (`ADDR_WIDTH+1)'(`SLAVE_DEPTH_1);  // idle master keeps full range
        endcase
    endfunction

    assign flags       = sw.sel.sid[0];
    assign ext_phase   = state inside {ext_write_m0, ext_write_m01, ext_write_m1};
    assign bank_we     = ext_phase && (addr_press || step_press);
    assign bank_master = (state == ext_write_m1);
    assign bank_addr   = wr_addr;
    assign bank_data   = sw[`DATA_WIDTH-1:0];

    assign val_master = (state == start_addr_m1) || (state == length_m1);
    assign span_end   = {1'b0, first_addr[val_master]} + {1'b0, sw.val.value};
    assign span_depth = depth_of(slave_id[val_master]);
    assign span_last  = (span_end >= span_depth) ? span_depth - 1'b1 : span_end;

    // idle masters never report done, so they are skipped
    always_comb begin
        all_done = 1'b1;
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            if (slave_id[m] != '0 && !done_com[m]) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= slave_select;
            slave_id   <= '0;
            rd_wr      <= '0;
            in_ex      <= '0;
            burst      <= '0;
            eoc        <= '0;
            first_addr <= '0;
            last_addr  <= '0;
            word_count <= '0;
            wr_addr    <= '0;
            cfg_go     <= 1'b0;
            launch     <= 1'b0;
        end else begin
            cfg_go <= 1'b0;
            launch <= 1'b0;
            if (bank_we) begin
                wr_addr                 <= step_press ? '0 : wr_addr + 1'b1;
                word_count[bank_master] <= word_count[bank_master] + 1'b1;
                if (!step_press) begin
                    burst[bank_master] <= 1'b1;  // more than one word entered
                end
            end
            if (state == configuring && cfg_done) begin
                state <= comm_ready;
            end
            if (state == communicating && all_done) begin
                state <= comm_done;
            end
            if (step_press) begin
                case (state)
                    slave_select: begin
                        slave_id <= sw.sel.sid;
                        eoc      <= {`MASTER_COUNT{sw.sel.sid == '0}};
                        state    <= (sw.sel.sid == '0) ? comm_done : rw_select;
                    end
                    rw_select: begin
                        rd_wr <= flags;
                        state <= ext_write_select;
                    end
                    ext_write_select: begin
                        in_ex <= flags;
                        case (flags)
                            2'b01:   state <= ext_write_m0;
                            2'b10:   state <= ext_write_m1;
                            2'b11:   state <= ext_write_m01;
                            default: state <= start_addr_m0;
                        endcase
                    end
                    ext_write_m01:              state <= ext_write_m1;
                    ext_write_m0, ext_write_m1: state <= start_addr_m0;
                    start_addr_m0, start_addr_m1: begin
                        first_addr[val_master] <= sw.val.value;
                        state <= val_master ? length_m0 : start_addr_m1;
                    end
                    length_m0, length_m1: begin
                        last_addr[val_master] <= span_last[`ADDR_WIDTH-1:0];
                        state  <= val_master ? configuring : length_m1;
                        cfg_go <= val_master;
                    end
                    comm_ready: begin
                        launch <= 1'b1;
                        state  <= communicating;
                    end
                    default: ;  // presses are dropped elsewhere
                endcase
            end
        end
    end

endmodule

// File: source/master_command_gen.sv
`timescale 1ns/1ns
`include "bus_ctrl_consts.svh"

module master_command_gen import bus_ctrl_pkg::*; (
    input  logic                                         clk,
    input  logic                                         rstN,
    input  logic                                         cfg_go,
    input  logic                                         launch,
    input  logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]    first_addr,
    input  logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]    last_addr,
    input  logic [`MASTER_COUNT-1:0][`BANK_ADDR_WIDTH:0] word_count,
    input  logic [`MASTER_COUNT-1:0]                     in_ex,
    input  logic [`DATA_WIDTH-1:0]                       rd_data,
    output logic                                         rd_master,
    output logic [`BANK_ADDR_WIDTH-1:0]                  rd_addr,
    output logic [`MASTER_COUNT-1:0]                     start,
    output logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]    address,
    output logic [`MASTER_COUNT-1:0][`DATA_WIDTH-1:0]    data,
    output logic                                         cfg_done
);
    config_state_t                              cstate;
    logic                                       cur;  // master being configured
    logic [$clog2(`CONFIG_CLK_COUNT+1)-1:0]     clk_cnt;
    logic [`BANK_ADDR_WIDTH-1:0]                word_idx;
    logic [`BANK_ADDR_WIDTH-1:0]                last_idx;
    logic                                       has_middle;
    logic                                       period_end;
    logic                                       issue;
    logic                                       launch_busy;
    logic [$clog2(`COM_START_DELAY+1)-1:0]      launch_cnt;

    assign rd_master  = cur;
    assign rd_addr    = word_idx;  // held for a whole period, so rd_data is valid at its end
    assign last_idx   = (in_ex[cur] && word_count[cur] != '0) ?
                        word_count[cur][`BANK_ADDR_WIDTH-1:0] - 1'b1 : '0;
    assign has_middle = in_ex[cur] && (word_count[cur] > 2);
    assign period_end = (clk_cnt == `CONFIG_CLK_COUNT - 1);
    assign issue      = period_end && (cstate != bus_ctrl_pkg::cfg_done);

    always_ff @(posedge clk) begin
        if (issue) begin
            data[cur] <= rd_data;
            if (cstate != cfg_middle) begin
                address[cur] <= (cstate == cfg_start) ? first_addr[cur] : last_addr[cur];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cstate      <= bus_ctrl_pkg::cfg_done;
            cur         <= 1'b0;
            clk_cnt     <= '0;
            word_idx    <= '0;
            start       <= '0;
            cfg_done    <= 1'b0;
            launch_busy <= 1'b0;
            launch_cnt  <= '0;
        end else begin
            start    <= '0;
            cfg_done <= 1'b0;
            clk_cnt  <= period_end ? '0 : clk_cnt + 1'b1;
            if (cfg_go) begin
                cstate   <= cfg_start;
                cur      <= 1'b0;
                clk_cnt  <= '0;
                word_idx <= '0;
            end else if (issue) begin
                case (cstate)
                    cfg_start: begin
                        start[cur] <= 1'b1;
                        word_idx   <= has_middle ? `BANK_ADDR_WIDTH'(1) : last_idx;
                        cstate     <= has_middle ? cfg_middle : cfg_last;
                    end
                    cfg_middle: begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx + 1'b1 == last_idx) begin
                            cstate <= cfg_last;
                        end
                    end
                    default: begin  // cfg_last
                        start[cur] <= 1'b1;
                        word_idx   <= '0;
                        if (cur == `MASTER_COUNT - 1) begin
                            cstate   <= bus_ctrl_pkg::cfg_done;
                            cfg_done <= 1'b1;
                        end else begin
                            cur    <= cur + 1'b1;
                            cstate <= cfg_start;
                        end
                    end
                endcase
            end
            // staggered launch of the two masters
            if (launch) begin
                start[`FIRST_START_MASTER] <= 1'b1;
                launch_busy                <= 1'b1;
                launch_cnt                 <= 1;
            end else if (launch_busy) begin
                launch_cnt <= launch_cnt + 1'b1;
                if (launch_cnt == `COM_START_DELAY) begin
                    start[`MASTER_COUNT-1-`FIRST_START_MASTER] <= 1'b1;
                    launch_busy                                <= 1'b0;
                end
            end
        end
    end

endmodule

// File: source/bus_ctrl_top.sv
`timescale 1ns/1ns
`include "bus_ctrl_consts.svh"

module bus_ctrl_top import bus_ctrl_pkg::*; (
    input  logic                                         clk,
    input  logic                                         rstN,
    input  logic [1:0]                                   key,  // 0 steps, 1 next address
    input  logic [`SW_WIDTH-1:0]                         sw,
    input  logic [`MASTER_COUNT-1:0]                     m_done_com,
    output logic [`MASTER_COUNT-1:0]                     m_start,
    output logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]    m_address,
    output logic [`MASTER_COUNT-1:0][`DATA_WIDTH-1:0]    m_data,
    output slave_id_t [`MASTER_COUNT-1:0]                m_slave_id,
    output logic [`MASTER_COUNT-1:0]                     m_rd_wr,
    output logic [`MASTER_COUNT-1:0]                     m_in_ex,
    output logic [`MASTER_COUNT-1:0]                     m_burst,
    output logic [`MASTER_COUNT-1:0]                     m_eoc,
    output logic                                         led_idle,
    output logic                                         led_ready,
    output logic                                         led_busy,
    output logic                                         led_done
);
    logic                                         step_press;
    logic                                         addr_press;
    session_state_t                               state;
    logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]    first_addr;
    logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]    last_addr;
    logic [`MASTER_COUNT-1:0][`BANK_ADDR_WIDTH:0] word_count;
    logic                                         bank_we;
    logic                                         bank_master;
    logic [`BANK_ADDR_WIDTH-1:0]                  bank_addr;
    logic [`DATA_WIDTH-1:0]                       bank_data;
    logic                                         cfg_go;
    logic                                         launch;
    logic                                         cfg_done;
    logic                                         rd_master;
    logic [`BANK_ADDR_WIDTH-1:0]                  rd_addr;
    logic [`DATA_WIDTH-1:0]                       rd_data;

    key_debouncer #(.DELAY_CYCLES(`DEBOUNCE_CYCLES)) step_db (
        .clk, .rstN, .key_n(key[0]), .press(step_press)
    );

    key_debouncer #(.DELAY_CYCLES(`DEBOUNCE_CYCLES)) addr_db (
        .clk, .rstN, .key_n(key[1]), .press(addr_press)
    );

    session_fsm session_fsm_i (
        .clk, .rstN, .step_press, .addr_press, .sw, .cfg_done,
        .done_com(m_done_com), .state, .slave_id(m_slave_id), .rd_wr(m_rd_wr),
        .in_ex(m_in_ex), .burst(m_burst), .eoc(m_eoc), .first_addr, .last_addr,
        .word_count, .bank_we, .bank_master, .bank_addr, .bank_data, .cfg_go, .launch
    );

    write_data_bank write_data_bank_i (
        .clk, .we(bank_we), .wr_master(bank_master), .wr_addr(bank_addr),
        .wr_data(bank_data), .rd_master, .rd_addr, .rd_data
    );

    master_command_gen master_command_gen_i (
        .clk, .rstN, .cfg_go, .launch, .first_addr, .last_addr, .word_count,
        .in_ex(m_in_ex), .rd_data, .rd_master, .rd_addr, .start(m_start),
        .address(m_address), .data(m_data), .cfg_done
    );

    assign led_idle  = (state == slave_select);
    assign led_ready = (state == comm_ready);     // configured, waiting for launch
    assign led_busy  = (state == communicating);
    assign led_done  = (state == comm_done);

endmodule

// File: tests/bus_ctrl_props.sv
`timescale 1ns/1ns
`include "bus_ctrl_consts.svh"

module bus_ctrl_props import bus_ctrl_pkg::*; (
    input logic                     clk,
    input logic                     rstN,
    input logic                     cfg_go,
    input logic                     launch,
    input logic [`MASTER_COUNT-1:0] burst,
    input session_state_t           state
);
    int violations = 0;  // count of failed assertions

    cfg_go_pulse: assert property (@(posedge clk) disable iff (!rstN) cfg_go |=> !cfg_go)
        else begin
            violations++;
            $error("cfg_go held high for more than one cycle");
        end

    launch_pulse: assert property (@(posedge clk) disable iff (!rstN) launch |=> !launch)
        else begin
            violations++;
            $error("launch held high for more than one cycle");
        end

    // a burst flag only clears through reset
    burst_sticky: assert property (@(posedge clk) disable iff (!rstN)
                                   ($past(burst) & ~burst) == '0)
        else begin
            violations++;
            $error("burst flag fell without a reset");
        end

    done_holds: assert property (@(posedge clk) disable iff (!rstN)
                                 state == comm_done |=> state == comm_done)
        else begin
            violations++;
            $error("session left comm_done without a reset");
        end

endmodule

// File: tests/bus_ctrl_tb.sv
`timescale 1ns/1ns
`include "bus_ctrl_consts.svh"

module bus_ctrl_tb import bus_ctrl_pkg::*; ();
    localparam int CLK_PERIOD     = 40;
    localparam int SESSIONS       = 12;
    localparam int PRESS_CYCLES   = 2 * `DEBOUNCE_CYCLES;
    localparam int MAX_WORDS      = 5;
    localparam int WAIT_LIMIT     = 64;  // cycles allowed for any DUT reaction
    localparam int SESSION_CYCLES = 20 * 2 * PRESS_CYCLES + 4 * WAIT_LIMIT;  // worst case
    localparam int WATCHDOG_NS    = (SESSIONS + 1) * SESSION_CYCLES * CLK_PERIOD;
    localparam int OTHER_MASTER   = `MASTER_COUNT - 1 - `FIRST_START_MASTER;

    logic                                       clk;
    logic                                       rstN;
    logic [1:0]                                 key;
    logic [`SW_WIDTH-1:0]                       sw;
    logic [`MASTER_COUNT-1:0]                   m_done_com;
    logic [`MASTER_COUNT-1:0]                   m_start;
    logic [`MASTER_COUNT-1:0][`ADDR_WIDTH-1:0]  m_address;
    logic [`MASTER_COUNT-1:0][`DATA_WIDTH-1:0]  m_data;
    slave_id_t [`MASTER_COUNT-1:0]              m_slave_id;
    logic [`MASTER_COUNT-1:0]                   m_rd_wr;
    logic [`MASTER_COUNT-1:0]                   m_in_ex;
    logic [`MASTER_COUNT-1:0]                   m_burst;
    logic [`MASTER_COUNT-1:0]                   m_eoc;
    logic [3:0]                                 leds;  // idle, ready, busy, done

    integer                                     seed = 32'h72;
    int                                         start_count [`MASTER_COUNT];
    slave_id_t [`MASTER_COUNT-1:0]              sid;  // session model
    logic [`MASTER_COUNT-1:0]                   rw;
    logic [`MASTER_COUNT-1:0]                   ext;
    int                                         nwords [`MASTER_COUNT];
    logic [`DATA_WIDTH-1:0]                     words [`MASTER_COUNT][`BANK_DEPTH];
    logic [`ADDR_WIDTH-1:0]                     first [`MASTER_COUNT];
    logic [`ADDR_WIDTH-1:0]                     len [`MASTER_COUNT];

    bus_ctrl_top bus_ctrl_top_i (
        .clk, .rstN, .key, .sw, .m_done_com, .m_start, .m_address, .m_data, .m_slave_id,
        .m_rd_wr, .m_in_ex, .m_burst, .m_eoc, .led_idle(leds[3]), .led_ready(leds[2]),
        .led_busy(leds[1]), .led_done(leds[0])
    );

    bind session_fsm bus_ctrl_props props_i (.clk, .rstN, .cfg_go, .launch, .burst, .state);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // start pulses per master since the last reset
    always @(posedge clk or negedge rstN) begin
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            if (!rstN) begin
                start_count[m] <= 0;
            end else if (m_start[m]) begin
                start_count[m] <= start_count[m] + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("Something failed");
        $fatal(1, "timeout");
    end

    initial begin
        wait (bus_ctrl_top_i.session_fsm_i.props_i.violations != 0);
        abort_run("a bound assertion on session_fsm failed");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_state(input string name, input session_state_t exp);
        logic [3:0] want;
        want = {exp == slave_select, exp == comm_ready, exp == communicating, exp == comm_done};
        if (leds !== want) begin
            abort_run($sformatf("Mismatch %s: expected %s (leds %b), actual leds %b",
                                name, exp.name(), want, leds));
        end
    endtask

    task automatic check_slave_id(input string name, input slave_id_t exp, input slave_id_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input logic [`MASTER_COUNT-1:0] exp,
                               input logic [`MASTER_COUNT-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [`ADDR_WIDTH-1:0] exp,
                              input logic [`ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected 'h%h, actual 'h%h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input logic [`DATA_WIDTH-1:0] exp,
                              input logic [`DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected 'h%h, actual 'h%h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // end address of a transfer, limited to the last word of the slave
    function automatic logic [`ADDR_WIDTH-1:0] clamp_last(input slave_id_t id,
            input logic [`ADDR_WIDTH-1:0] start, input logic [`ADDR_WIDTH-1:0] length);
        int depth;
        int span;
        depth = (id == 2'd3) ? `SLAVE_DEPTH_3 : (id == 2'd2) ? `SLAVE_DEPTH_2 : `SLAVE_DEPTH_1;
        span  = int'(start) + int'(length);
        return (span >= depth) ? `ADDR_WIDTH'(depth - 1) : `ADDR_WIDTH'(span);
    endfunction

    task automatic reset_dut();
        @(negedge clk);
        rstN       = 1'b0;
        key        = 2'b11;
        sw         = '0;
        m_done_com = '0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
    endtask

    task automatic press_key(input int k, input logic [`SW_WIDTH-1:0] value);
        @(negedge clk);
        sw     = value;
        key[k] = 1'b0;  // keys are active low
        repeat (PRESS_CYCLES) @(negedge clk);
        key[k] = 1'b1;
        repeat (PRESS_CYCLES) @(negedge clk);
    endtask

    task automatic wait_start(input int m, input string what);
        for (int t = 0; t < WAIT_LIMIT; t++) begin
            @(negedge clk);
            if (m_start[m]) begin
                return;
            end
        end
        abort_run($sformatf("timeout: master %0d got no start pulse during %s", m, what));
    endtask

    task automatic plan_session();
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            sid[m] = slave_id_t'($random(seed));
        end
        if (sid == '0) begin
            sid[1] = 2'd3;  // all idle is its own test
        end
        rw  = `MASTER_COUNT'($random(seed));
        ext = `MASTER_COUNT'($random(seed));
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            nwords[m] = ext[m] ? 1 + int'($unsigned($random(seed)) % MAX_WORDS) : 0;
            for (int i = 0; i < `BANK_DEPTH; i++) begin
                words[m][i] = `DATA_WIDTH'($random(seed));
            end
            first[m] = `ADDR_WIDTH'($random(seed));
            len[m]   = `ADDR_WIDTH'($random(seed));
        end
    endtask

    // every word but the last moves the address and the step key ends the phase
    task automatic enter_words(input int m);
        for (int i = 0; i < nwords[m] - 1; i++) begin
            press_key(1, `SW_WIDTH'(words[m][i]));
        end
        press_key(0, `SW_WIDTH'(words[m][nwords[m] - 1]));
    endtask

    task automatic check_config(input string tn);
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            wait_start(m, {tn, " configuration"});
            check_addr($sformatf("%s m%0d first address", tn, m), first[m], m_address[m]);
            if (ext[m]) begin
                check_data($sformatf("%s m%0d word 0", tn, m), words[m][0], m_data[m]);
            end
            for (int i = 1; i < nwords[m] - 1; i++) begin
                repeat (`CONFIG_CLK_COUNT) @(negedge clk);
                check_data($sformatf("%s m%0d word %0d", tn, m, i), words[m][i], m_data[m]);
            end
            wait_start(m, {tn, " configuration"});
            check_addr($sformatf("%s m%0d last address", tn, m),
                       clamp_last(sid[m], first[m], len[m]), m_address[m]);
            if (ext[m]) begin
                check_data($sformatf("%s m%0d last word", tn, m),
                           words[m][nwords[m] - 1], m_data[m]);
            end
        end
    endtask

    task automatic check_launch(input string tn);
        int gap;
        wait_start(`FIRST_START_MASTER, {tn, " launch"});
        check_flags({tn, " launch pulses"}, `MASTER_COUNT'(1 << `FIRST_START_MASTER), m_start);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!m_start[OTHER_MASTER] && gap < WAIT_LIMIT);
        check_count({tn, " launch stagger"}, `COM_START_DELAY, gap);
    endtask

    task automatic run_completion(input string tn);
        int                       lat [`MASTER_COUNT];
        logic [`MASTER_COUNT-1:0] active;
        logic [`MASTER_COUNT-1:0] raised;
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            lat[m]    = int'($unsigned($random(seed)) % 24);
            active[m] = (sid[m] != '0);  // idle masters never report done
        end
        raised = '0;
        for (int t = 0; t < WAIT_LIMIT; t++) begin
            @(negedge clk);
            if (leds[0]) begin
                check_flags({tn, " masters done at comm_done"}, active, active & raised);
                check_flags({tn, " eoc"}, '0, m_eoc);
                return;
            end
            check_state({tn, " communicating"}, communicating);
            for (int m = 0; m < `MASTER_COUNT; m++) begin
                if (active[m] && t == lat[m]) begin
                    m_done_com[m] = 1'b1;
                    raised[m]     = 1'b1;
                end
            end
        end
        abort_run($sformatf("timeout: %s never reached comm_done", tn));
    endtask

    task automatic run_idle_session();
        reset_dut();
        check_state("reset", slave_select);
        check_flags("reset start pulses", '0, m_start);
        check_flags("reset burst", '0, m_burst);
        press_key(0, '0);
        check_state("no slave selected", comm_done);
        check_flags("no slave selected eoc", '1, m_eoc);
        check_count("no slave selected starts", 0, start_count[0] + start_count[1]);
    endtask

    task automatic run_session(input int n);
        string                    tn;
        logic [`MASTER_COUNT-1:0] burst_exp;
        tn = $sformatf("session %0d", n);
        plan_session();
        reset_dut();
        check_state({tn, " reset"}, slave_select);
        check_flags({tn, " reset eoc"}, '0, m_eoc);
        press_key(0, `SW_WIDTH'(sid));
        press_key(0, `SW_WIDTH'(rw));
        press_key(0, `SW_WIDTH'(ext));
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            if (ext[m]) begin
                enter_words(m);
            end
            burst_exp[m] = ext[m] && nwords[m] > 1;
        end
        press_key(0, `SW_WIDTH'(first[0]));
        press_key(0, `SW_WIDTH'(first[1]));
        press_key(0, `SW_WIDTH'(len[0]));
        fork
            press_key(0, `SW_WIDTH'(len[1]));
            check_config(tn);
        join
        @(negedge clk);
        check_state({tn, " configured"}, comm_ready);
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            check_slave_id($sformatf("%s m%0d slave id", tn, m), sid[m], m_slave_id[m]);
        end
        check_flags({tn, " rd_wr"}, rw, m_rd_wr);
        check_flags({tn, " in_ex"}, ext, m_in_ex);
        check_flags({tn, " burst"}, burst_exp, m_burst);
        fork
            press_key(0, '0);
            check_launch(tn);
        join
        run_completion(tn);
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            check_count($sformatf("%s m%0d start pulses", tn, m), 3, start_count[m]);
        end
    endtask

    initial begin
        rstN       = 1'b0;
        key        = 2'b11;
        sw         = '0;
        m_done_com = '0;
        run_idle_session();
        for (int n = 0; n < SESSIONS; n++) begin
            run_session(n);
        end
        if (bus_ctrl_top_i.session_fsm_i.props_i.violations == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d assertion failures",
                     bus_ctrl_top_i.session_fsm_i.props_i.violations);
            $display("Something failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: verilog.f
+incdir+source
source/bus_ctrl_pkg.sv
source/key_debouncer.sv
source/write_data_bank.sv
source/session_fsm.sv
source/master_command_gen.sv
source/bus_ctrl_top.sv
tests/bus_ctrl_props.sv
tests/bus_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= bus_ctrl_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
